// ==== bench/panel_fill_checker.sv ====
// Shadow frame model and read-back checker
`default_nettype none
`timescale 1ns/1ns

`include "panel_config.svh"

module panel_fill_checker (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic [7:0]          data_in,
    input  wire logic                enable,
    input  wire logic                ready_for_data,
    input  wire logic                done,
    input  wire panel_pkg::fb_addr_t rd_addr,
    input  wire logic [7:0]          rd_data,
    input  wire logic                check_en,
    output int                       errors,
    output int                       compared
);
    import panel_pkg::*;

    logic [7:0]   shadow [`FB_DEPTH];
    fill_region_t region;
    color_t       color;
    int           phase;
    int           count;
    logic         pending;
    logic         prev_check;
    fb_addr_t     prev_addr;

    function automatic int flat_index(input int row, input int col, input int pixel);
        return (row * `PANEL_WIDTH + col) * `BYTES_PER_PIXEL + pixel;
    endfunction

    // the area is cut at the panel edges and is empty when its origin lies off the panel.
    task automatic apply_fill();
        int x_end;
        int y_end;
        x_end = int'(region.x1) + int'(region.width);
        y_end = int'(region.y1) + int'(region.height);
        if (x_end > `PANEL_WIDTH) x_end = `PANEL_WIDTH;
        if (y_end > `PANEL_HEIGHT) y_end = `PANEL_HEIGHT;
        for (int y = int'(region.y1); y < y_end; y++) begin
            for (int x = int'(region.x1); x < x_end; x++) begin
                shadow[flat_index(y, x, 0)] = color.red;
                shadow[flat_index(y, x, 1)] = color.green;
                shadow[flat_index(y, x, 2)] = color.blue;
            end
        end
    endtask

    task automatic take_byte(input logic [7:0] b);
        if (phase == 0) begin
            count = 0;
            if (b == OP_FILL_PANEL) begin
                region = '{x1: 8'd0, y1: 8'd0,
                           width: 8'(`PANEL_WIDTH), height: 8'(`PANEL_HEIGHT)};
                phase = 2;
            end else if (b == OP_FILL_AREA) begin
                phase = 1;
            end
        end else if (phase == 1) begin
            case (count)
                0: region.x1 = b;
                1: region.y1 = b;
                2: region.width = b;
                default: region.height = b;
            endcase
            count++;
            if (count == 4) begin
                phase = 2;
                count = 0;
            end
        end else begin
            case (count)
                0: color.red = b;
                1: color.green = b;
                default: color.blue = b;
            endcase
            count++;
            if (count == `BYTES_PER_PIXEL) begin
                apply_fill();
                pending = 1'b1;
                phase = 0;
            end
        end
    endtask

    // Inputs change shortly after the rising edge, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (reset) begin
            phase = 0;
            count = 0;
            pending = 1'b0;
            prev_check = 1'b0;
        end else begin
            if (prev_check) begin
                compared++;
                if (rd_data !== shadow[flat_index(int'(prev_addr.row), int'(prev_addr.col),
                                                  int'(prev_addr.pixel))]) begin
                    $display("mismatch at %0t ns: row %0d col %0d byte %0d expected %02h got %02h",
                             $time, prev_addr.row, prev_addr.col, prev_addr.pixel,
                             shadow[flat_index(int'(prev_addr.row), int'(prev_addr.col),
                                               int'(prev_addr.pixel))], rd_data);
                    errors++;
                end
            end
            prev_check = check_en;
            prev_addr = rd_addr;
            if (done) begin
                if (!pending) begin
                    $display("error at %0t ns: done pulsed with no command outstanding", $time);
                    errors++;
                end
                pending = 1'b0;
            end
            if (enable && ready_for_data) begin
                take_byte(data_in);
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/panel_fill_tb.sv ====
// Panel fill unit testbench
`default_nettype none
`timescale 1ns/1ns

`include "panel_config.svh"

module panel_fill_tb;
    import panel_pkg::*;

    localparam int N_TESTS = 9;
    localparam int PIXELS = `PANEL_WIDTH * `PANEL_HEIGHT;
    localparam int FILL_BOUND = `BYTES_PER_PIXEL * PIXELS + 16;
    localparam int WATCHDOG_CYCLES = N_TESTS * (`FB_DEPTH + 3 * PIXELS + 64) + 16;

    logic       clk;
    logic       reset;
    logic [7:0] data_in;
    logic       enable;
    logic       ready_for_data;
    logic       done;
    fb_addr_t   rd_addr;
    logic [7:0] rd_data;
    logic       check_en;
    int         check_errors;
    int         compared;
    int         tb_errors;
    int         seed;
    int         n_rows;

    // command table, one fill per row.
    string        test_name [N_TESTS];
    logic         lead_junk [N_TESTS];
    logic [7:0]   opcode [N_TESTS];
    fill_region_t geom [N_TESTS];
    color_t       fill_color [N_TESTS];
    logic         rand_color [N_TESTS];

    panel_fill_top panel_fill_top_i (
        .clk            (clk),
        .reset          (reset),
        .data_in        (data_in),
        .enable         (enable),
        .ready_for_data (ready_for_data),
        .done           (done),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data)
    );

    panel_fill_checker frame_check_i (
        .clk            (clk),
        .reset          (reset),
        .data_in        (data_in),
        .enable         (enable),
        .ready_for_data (ready_for_data),
        .done           (done),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .check_en       (check_en),
        .errors         (check_errors),
        .compared       (compared)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic add_row(input string name, input logic junk, input logic [7:0] op,
                           input fill_region_t g, input color_t c, input logic rnd);
        test_name[n_rows] = name;
        lead_junk[n_rows] = junk;
        opcode[n_rows] = op;
        geom[n_rows] = g;
        fill_color[n_rows] = c;
        rand_color[n_rows] = rnd;
        n_rows++;
    endtask

    // holds the byte until a clock where the unit takes it.
    task automatic send_byte(input logic [7:0] b);
        data_in = b;
        enable = 1'b1;
        while (!ready_for_data) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
    endtask

    // offers junk while the fill runs, then waits for done.
    task automatic finish_command(input string name);
        int waited;
        data_in = 8'ha5;
        enable = 1'b1;
        repeat (2) begin
            if (ready_for_data) begin
                $display("error at %0t ns: ready_for_data high while a fill runs", $time);
                tb_errors++;
            end
            @(posedge clk);
            #2;
        end
        enable = 1'b0;
        waited = 0;
        while (!done && waited < FILL_BOUND) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!done) begin
            $display("error: no done pulse within %0d cycles in test %s", FILL_BOUND, name);
            tb_errors++;
        end
    endtask

    task automatic sweep_frame();
        check_en = 1'b1;
        for (int r = 0; r < `PANEL_HEIGHT; r++) begin
            for (int c = 0; c < `PANEL_WIDTH; c++) begin
                for (int p = 0; p < `BYTES_PER_PIXEL; p++) begin
                    rd_addr = '{row: row_addr_t'(r), col: col_addr_t'(c),
                                pixel: pixel_byte_t'(p)};
                    @(posedge clk);
                    #2;
                end
            end
        end
        check_en = 1'b0;
        repeat (2) @(posedge clk);
        #2;
    endtask

    initial begin
        int     err_before;
        int     passed;
        int     failed;
        color_t c;
        data_in = 8'h00;
        enable = 1'b0;
        rd_addr = '0;
        check_en = 1'b0;
        reset = 1'b1;
        tb_errors = 0;
        passed = 0;
        failed = 0;
        n_rows = 0;
        seed = 32'h7b8a;

        // geometry is x1, y1, width, height.
        add_row("fill panel", 1'b0, OP_FILL_PANEL, '0, 24'h112233, 1'b0);
        add_row("area inside", 1'b0, OP_FILL_AREA, {8'd2, 8'd1, 8'd5, 8'd3}, 24'ha0b1c2, 1'b0);
        add_row("area clipped", 1'b0, OP_FILL_AREA, {8'd12, 8'd5, 8'd10, 8'd10},
                24'h445566, 1'b0);
        add_row("area x1 off panel", 1'b0, OP_FILL_AREA, {8'd16, 8'd2, 8'd3, 8'd3},
                24'hddeeff, 1'b0);
        add_row("area y1 off panel", 1'b0, OP_FILL_AREA, {8'd4, 8'd8, 8'd3, 8'd3},
                24'h778899, 1'b0);
        add_row("unknown opcode", 1'b1, OP_FILL_AREA, {8'd0, 8'd0, 8'd3, 8'd2},
                24'h0f1e2d, 1'b0);
        add_row("random panel", 1'b0, OP_FILL_PANEL, '0, '0, 1'b1);
        add_row("random area", 1'b0, OP_FILL_AREA, {8'd7, 8'd3, 8'd4, 8'd4}, '0, 1'b1);
        add_row("random clipped", 1'b0, OP_FILL_AREA, {8'd14, 8'd6, 8'd8, 8'd8}, '0, 1'b1);

        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        if (!ready_for_data || done) begin
            $display("error: after reset ready_for_data is %b and done is %b",
                     ready_for_data, done);
            tb_errors++;
        end

        for (int i = 0; i < n_rows; i++) begin
            err_before = check_errors + tb_errors;
            c = fill_color[i];
            if (rand_color[i]) begin
                c.red = 8'($random(seed));
                c.green = 8'($random(seed));
                c.blue = 8'($random(seed));
            end
            if (lead_junk[i]) send_byte(8'h7e);
            send_byte(opcode[i]);
            if (opcode[i] == OP_FILL_AREA) begin
                send_byte(geom[i].x1);
                send_byte(geom[i].y1);
                send_byte(geom[i].width);
                send_byte(geom[i].height);
            end
            send_byte(c.red);
            send_byte(c.green);
            send_byte(c.blue);
            finish_command(test_name[i]);
            sweep_frame();
            if (check_errors + tb_errors == err_before) begin
                $display("test %s: ok", test_name[i]);
                passed++;
            end else begin
                $display("test %s: failed with %0d errors", test_name[i],
                         check_errors + tb_errors - err_before);
                failed++;
            end
        end

        $display("tests run %0d, passed %0d, failed %0d, bytes compared %0d, errors %0d",
                 n_rows, passed, failed, compared, check_errors + tb_errors);
        if (check_errors + tb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/fill_area_engine.sv ====
// Clipped rectangle fill engine
`default_nettype none
`timescale 1ns/1ns

`include "panel_config.svh"

module fill_area_engine (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    start,
    input  wire panel_pkg::fill_region_t region,
    input  wire panel_pkg::color_t       color,
    output logic                         busy,
    output logic                         finished,
    output logic                         wr_en,
    output panel_pkg::fb_addr_t          wr_addr,
    output logic [7:0]                   wr_data
);
    import panel_pkg::*;

    fb_addr_t   pos;
    col_addr_t  col_first;
    col_addr_t  col_last;
    row_addr_t  row_last;
    logic [8:0] col_span_end;
    logic [8:0] row_span_end;
    logic       area_empty;
    logic       last_write;

    // an area starting off the panel, or with no size, writes nothing.
    assign area_empty = (region.x1 >= 8'(`PANEL_WIDTH)) || (region.y1 >= 8'(`PANEL_HEIGHT))
                     || (region.width == 8'd0) || (region.height == 8'd0);
    assign col_span_end = {1'b0, region.x1} + {1'b0, region.width} - 9'd1;
    assign row_span_end = {1'b0, region.y1} + {1'b0, region.height} - 9'd1;

    assign last_write = (pos.pixel == pixel_byte_t'(`BYTES_PER_PIXEL - 1))
                     && (pos.col == col_last) && (pos.row == row_last);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (busy) begin
                if (last_write) begin
                    busy     <= 1'b0;
                    finished <= 1'b1;
                end
            end else if (start) begin
                busy     <= !area_empty;
                finished <= area_empty;
            end
        end
    end

    // byte index is the inner counter, then column, then row.
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            pos       <= '{row: row_addr_t'(region.y1), col: col_addr_t'(region.x1), pixel: '0};
            col_first <= col_addr_t'(region.x1);
            col_last  <= (col_span_end >= 9'(`PANEL_WIDTH)) ?
                         col_addr_t'(`PANEL_WIDTH - 1) : col_addr_t'(col_span_end);
            row_last  <= (row_span_end >= 9'(`PANEL_HEIGHT)) ?
                         row_addr_t'(`PANEL_HEIGHT - 1) : row_addr_t'(row_span_end);
        end else if (busy) begin
            if (pos.pixel == pixel_byte_t'(`BYTES_PER_PIXEL - 1)) begin
                pos.pixel <= '0;
                if (pos.col == col_last) begin
                    pos.col <= col_first;
                    pos.row <= pos.row + row_addr_t'(1);
                end else begin
                    pos.col <= pos.col + col_addr_t'(1);
                end
            end else begin
                pos.pixel <= pos.pixel + pixel_byte_t'(1);
            end
        end
    end

    assign wr_en   = busy;
    assign wr_addr = pos;

    always_comb begin
        case (pos.pixel)
            pixel_byte_t'(0): wr_data = color.red;
            pixel_byte_t'(1): wr_data = color.green;
            default: wr_data = color.blue;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/fill_cmd_ctrl.sv ====
// Fill command controller
`default_nettype none
`timescale 1ns/1ns

`include "panel_config.svh"

module fill_cmd_ctrl (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic [7:0]              data_in,
    input  wire logic                    enable,
    output logic                         ready_for_data,
    output logic                         done,
    output logic                         load_region,
    output logic [1:0]                   region_slot,
    output logic                         load_color,
    output panel_pkg::pixel_byte_t       color_slot,
    output logic                         set_full_panel,
    output logic [7:0]                   load_byte,
    output logic                         start,
    input  wire logic                    finished
);
    import panel_pkg::*;

    typedef enum logic [2:0] {
        S_OPCODE,
        S_GEOM,
        S_COLOR,
        S_START,
        S_RUN,
        S_DONE
    } ctrl_state_t;

    ctrl_state_t state;
    logic [1:0]  geom_count;
    pixel_byte_t color_count;
    logic        byte_taken;
    logic        opcode_phase;

    // the done state also accepts the next opcode, since ready is already high.
    assign opcode_phase   = (state == S_OPCODE) || (state == S_DONE);
    assign ready_for_data = opcode_phase || (state == S_GEOM) || (state == S_COLOR);
    assign byte_taken     = enable && ready_for_data;

    assign done  = (state == S_DONE);
    assign start = (state == S_START);

    assign load_byte      = data_in;
    assign region_slot    = geom_count;
    assign color_slot     = color_count;
    assign load_region    = byte_taken && (state == S_GEOM);
    assign load_color     = byte_taken && (state == S_COLOR);
    assign set_full_panel = byte_taken && opcode_phase && (data_in == OP_FILL_PANEL);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= S_OPCODE;
            geom_count  <= '0;
            color_count <= '0;
        end else begin
            case (state)
                S_OPCODE, S_DONE: begin
                    state <= S_OPCODE;
                    if (byte_taken) begin
                        geom_count  <= '0;
                        color_count <= '0;
                        // unknown opcodes are simply dropped here.
                        if (data_in == OP_FILL_PANEL) begin
                            state <= S_COLOR;
                        end else if (data_in == OP_FILL_AREA) begin
                            state <= S_GEOM;
                        end
                    end
                end
                S_GEOM: begin
                    if (byte_taken) begin
                        geom_count <= geom_count + 2'd1;
                        if (geom_count == 2'd3) begin
                            state <= S_COLOR;
                        end
                    end
                end
                S_COLOR: begin
                    if (byte_taken) begin
                        if (color_count == pixel_byte_t'(`BYTES_PER_PIXEL - 1)) begin
                            state <= S_START;
                        end else begin
                            color_count <= color_count + pixel_byte_t'(1);
                        end
                    end
                end
                S_START: begin
                    state <= S_RUN;
                end
                S_RUN: begin
                    if (finished) begin
                        state <= S_DONE;
                    end
                end
                default: begin
                    state <= S_OPCODE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fill_region_regs.sv ====
// Fill region and color registers
`default_nettype none
`timescale 1ns/1ns

`include "panel_config.svh"

module fill_region_regs (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    load_region,
    input  wire logic [1:0]              region_slot,
    input  wire logic                    load_color,
    input  wire panel_pkg::pixel_byte_t  color_slot,
    input  wire logic                    set_full_panel,
    input  wire logic [7:0]              load_byte,
    output panel_pkg::fill_region_t      region,
    output panel_pkg::color_t            color
);
    import panel_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            region <= '0;
            color  <= '0;
        end else begin
            if (set_full_panel) begin
                region <= '{x1: 8'd0, y1: 8'd0,
                            width: 8'(`PANEL_WIDTH), height: 8'(`PANEL_HEIGHT)};
            end else if (load_region) begin
                case (region_slot)
                    2'd0: region.x1 <= load_byte;
                    2'd1: region.y1 <= load_byte;
                    2'd2: region.width <= load_byte;
                    default: region.height <= load_byte;
                endcase
            end
            // color bytes arrive red first.
            if (load_color) begin
                case (color_slot)
                    pixel_byte_t'(0): color.red <= load_byte;
                    pixel_byte_t'(1): color.green <= load_byte;
                    default: color.blue <= load_byte;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/frame_buffer.sv ====
// Frame buffer RAM
`default_nettype none
`timescale 1ns/1ns

`include "panel_config.svh"

module frame_buffer (
    input  wire logic                clk,
    input  wire logic                wr_en,
    input  wire panel_pkg::fb_addr_t wr_addr,
    input  wire logic [7:0]          wr_data,
    input  wire panel_pkg::fb_addr_t rd_addr,
    output logic [7:0]               rd_data
);
    import panel_pkg::*;

    localparam int IDX_W = $clog2(`FB_DEPTH);

    logic [7:0] mem [`FB_DEPTH];

    // pixels are stored row by row, three bytes each.
    function automatic logic [IDX_W-1:0] flat_index(input fb_addr_t a);
        logic [IDX_W-1:0] pixel_index;
        pixel_index = IDX_W'(a.row) * IDX_W'(`PANEL_WIDTH) + IDX_W'(a.col);
        return pixel_index * IDX_W'(`BYTES_PER_PIXEL) + IDX_W'(a.pixel);
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[flat_index(wr_addr)] <= wr_data;
        end
        rd_data <= mem[flat_index(rd_addr)];
    end

endmodule

`default_nettype wire

// ==== rtl/panel_config.svh ====
// Panel geometry constants
`ifndef PANEL_CONFIG_SVH
`define PANEL_CONFIG_SVH

// columns across the panel.
`define PANEL_WIDTH 16

// rows down the panel.
`define PANEL_HEIGHT 8

// red, green and blue bytes per pixel.
`define BYTES_PER_PIXEL 3

// total frame buffer bytes.
`define FB_DEPTH (`PANEL_WIDTH * `PANEL_HEIGHT * `BYTES_PER_PIXEL)

`endif

// ==== rtl/panel_fill_top.sv ====
// Panel fill unit top level
`default_nettype none
`timescale 1ns/1ns

module panel_fill_top (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic [7:0]          data_in,
    input  wire logic                enable,
    output logic                     ready_for_data,
    output logic                     done,
    input  wire panel_pkg::fb_addr_t rd_addr,
    output logic [7:0]               rd_data
);
    import panel_pkg::*;

    logic         load_region;
    logic [1:0]   region_slot;
    logic         load_color;
    pixel_byte_t  color_slot;
    logic         set_full_panel;
    logic [7:0]   load_byte;
    logic         start;
    logic         finished;
    fill_region_t region;
    color_t       color;
    logic         wr_en;
    fb_addr_t     wr_addr;
    logic [7:0]   wr_data;

    fill_cmd_ctrl fill_cmd_ctrl_i (
        .clk            (clk),
        .reset          (reset),
        .data_in        (data_in),
        .enable         (enable),
        .ready_for_data (ready_for_data),
        .done           (done),
        .load_region    (load_region),
        .region_slot    (region_slot),
        .load_color     (load_color),
        .color_slot     (color_slot),
        .set_full_panel (set_full_panel),
        .load_byte      (load_byte),
        .start          (start),
        .finished       (finished)
    );

    fill_region_regs fill_region_regs_i (
        .clk            (clk),
        .reset          (reset),
        .load_region    (load_region),
        .region_slot    (region_slot),
        .load_color     (load_color),
        .color_slot     (color_slot),
        .set_full_panel (set_full_panel),
        .load_byte      (load_byte),
        .region         (region),
        .color          (color)
    );

    fill_area_engine fill_area_engine_i (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .region   (region),
        .color    (color),
        .busy     (),
        .finished (finished),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    frame_buffer frame_buffer_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// ==== rtl/panel_pkg.sv ====
// Panel fill types
`default_nettype none

`include "panel_config.svh"

package panel_pkg;

    typedef logic [$clog2(`PANEL_WIDTH)-1:0] col_addr_t;
    typedef logic [$clog2(`PANEL_HEIGHT)-1:0] row_addr_t;
    typedef logic [$clog2(`BYTES_PER_PIXEL)-1:0] pixel_byte_t;

    // addresses one frame buffer byte with the byte index in the low bits.
    typedef struct packed {
        row_addr_t   row;
        col_addr_t   col;
        pixel_byte_t pixel;
    } fb_addr_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } color_t;

    // full bytes, so the host may request areas past the panel edge.
    typedef struct packed {
        logic [7:0] x1;
        logic [7:0] y1;
        logic [7:0] width;
        logic [7:0] height;
    } fill_region_t;

    localparam logic [7:0] OP_FILL_PANEL = 8'h01;
    localparam logic [7:0] OP_FILL_AREA  = 8'h02;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the panel fill testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f vlog.f --top-module panel_fill_tb -o panel_fill_sim
./obj_dir/panel_fill_sim | tee sim.log

if grep -qF "PASS: all tests" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== vlog.f ====
+incdir+rtl
rtl/panel_pkg.sv
rtl/fill_region_regs.sv
rtl/fill_cmd_ctrl.sv
rtl/fill_area_engine.sv
rtl/frame_buffer.sv
rtl/panel_fill_top.sv
bench/panel_fill_checker.sv
bench/panel_fill_tb.sv
